// ==== Bender.yml ====
package:
  name: ex_stage

sources:
  # RTL, package first
  - files:
      - src/ex_pkg.sv
      - src/ex_alu.sv
      - src/ex_mult.sv
      - src/ex_fwd_stall.sv
      - src/ex_wb_reg.sv
      - src/ex_stage.sv

  # Testbench
  - target: test
    files:
      - tb/tb_clkgen.sv
      - tb/ex_stage_properties.sv
      - tb/ex_stage_tb.sv

// ==== filelist.f ====
src/ex_pkg.sv
src/ex_alu.sv
src/ex_mult.sv
src/ex_fwd_stall.sv
src/ex_wb_reg.sv
src/ex_stage.sv
tb/tb_clkgen.sv
tb/ex_stage_properties.sv
tb/ex_stage_tb.sv

// ==== src/ex_alu.sv ====
// Combinational ALU: add/sub, logic, shifts, set-less-than and branch comparisons

`timescale 1ns/1ps

module ex_alu import ex_pkg::*; (
  input  alu_req_t alu_req_i,
  output word_t    result_o,
  output logic     cmp_result_o
);

  // Operand aliases
  word_t              op_a;
  word_t              op_b;
  logic [SHAMT_W-1:0] shamt;

  // Shared comparator outputs
  logic               is_eq;
  logic               lt_signed;
  logic               lt_unsigned;

  // Comparison flag before it goes out
  logic               cmp;

  assign op_a  = alu_req_i.operand_a;
  assign op_b  = alu_req_i.operand_b;
  // Only the low 5 bits of B count for shifts
  assign shamt = op_b[SHAMT_W-1:0];

  ////////////////////
  // Comparator
  ////////////////////

  // One equality and two less-than checks serve every compare op
  assign is_eq       = (op_a == op_b);
  assign lt_signed   = ($signed(op_a) < $signed(op_b));
  assign lt_unsigned = (op_a < op_b);

  // Branch flag select
  always_comb begin
    cmp = 1'b0;
    unique case (alu_req_i.op)
      EQ:        cmp = is_eq;
      NE:        cmp = ~is_eq;
      // SLT shares the signed less-than with the branch
      LT, SLT:   cmp = lt_signed;
      GE:        cmp = ~lt_signed;
      LTU, SLTU: cmp = lt_unsigned;
      GEU:       cmp = ~lt_unsigned;
      // Arithmetic, logic and shift ops give no branch
      default:   cmp = 1'b0;
    endcase
  end

  assign cmp_result_o = cmp;

  ////////////////////
  // Result mux
  ////////////////////

  always_comb begin
    unique case (alu_req_i.op)
      // Adder
      ADD:     result_o = op_a + op_b;
      SUB:     result_o = op_a - op_b;

      // Bitwise logic
      AND:     result_o = op_a & op_b;
      OR:      result_o = op_a | op_b;
      XOR:     result_o = op_a ^ op_b;

      // Shifter
      SLL:     result_o = op_a << shamt;
      SRL:     result_o = op_a >> shamt;
      // Arithmetic shift keeps the sign bit
      SRA:     result_o = word_t'($signed(op_a) >>> shamt);

      // All comparisons return the flag as 0 or 1
      default: result_o = {{(DATA_W-1){1'b0}}, cmp};
    endcase
  end

endmodule

// ==== src/ex_fwd_stall.sv ====
// Forwarding write port mux and the ex_ready/ex_valid stall logic

`timescale 1ns/1ps

module ex_fwd_stall import ex_pkg::*; (
  // Unit enables from ID
  input  logic     alu_en_i,
  input  logic     mult_en_i,
  input  logic     csr_access_i,
  input  logic     lsu_en_i,

  // Candidate write data
  input  word_t    alu_result_i,
  input  word_t    mult_result_i,
  input  word_t    csr_rdata_i,

  // ALU port write control from ID
  input  wb_ctrl_t alu_wb_i,

  // Readiness of the units and later stages
  input  logic     mult_ready_i,
  input  logic     lsu_ready_ex_i,
  input  logic     wb_ready_i,
  input  logic     branch_in_ex_i,

  // Forwarding port to RF and ID
  output wb_ctrl_t fwd_o,
  output word_t    fwd_wdata_o,

  output logic     ex_ready_o,
  output logic     ex_valid_o
);

  // All units able to take or finish work
  logic units_ready;
  // Some unit has an instruction in EX
  logic any_en;

  ////////////////////
  // Forwarding port
  ////////////////////

  // Address and enable come straight from ID
  assign fwd_o = alu_wb_i;

  // CSR wins over MUL, MUL wins over ALU
  always_comb begin
    if (csr_access_i) begin
      fwd_wdata_o = csr_rdata_i;
    end else if (mult_en_i) begin
      fwd_wdata_o = mult_result_i;
    end else if (alu_en_i) begin
      fwd_wdata_o = alu_result_i;
    end else begin
      fwd_wdata_o = '0;
    end
  end

  ////////////////////
  // Stall logic
  ////////////////////

  assign units_ready = mult_ready_i & lsu_ready_ex_i & wb_ready_i;
  assign any_en      = alu_en_i | mult_en_i | csr_access_i | lsu_en_i;

  // Branches resolve in EX, no need to wait for the later stages
  assign ex_ready_o = units_ready | branch_in_ex_i;
  // Valid goes forward only, independent of the branch override
  assign ex_valid_o = any_en & units_ready;

endmodule

// ==== src/ex_mult.sv ====
// Multiplier: single-cycle MUL/MAC low path and a two-cycle MULH high-half FSM

`timescale 1ns/1ps

module ex_mult import ex_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,

  input  logic      mult_en_i,
  input  mult_req_t mult_req_i,
  // Result consumed when the stage moves on
  input  logic      ex_ready_i,

  output word_t     result_o,
  output logic      ready_o,
  output logic      multicycle_o
);

  // Low product path
  word_t                     mul_lo;
  word_t                     mac_lo;

  // Sign-extended operands for MULH, one extra bit each
  logic signed [DATA_W:0]    op_a_ext;
  logic signed [DATA_W:0]    op_b_ext;
  logic signed [2*DATA_W+1:0] prod_full;

  // Registered full product
  logic [2*DATA_W-1:0]       prod_q;

  // High-half FSM
  mult_state_e               state_q;
  mult_state_e               state_d;
  logic                      mulh_start;

  ////////////////////
  // Datapath
  ////////////////////

  // Low 32 bits are the same for signed and unsigned operands
  assign mul_lo = mult_req_i.operand_a * mult_req_i.operand_b;
  assign mac_lo = mul_lo + mult_req_i.operand_c;

  // Sign bit only when the mode asks for it
  assign op_a_ext  = {mult_req_i.signed_mode[1] & mult_req_i.operand_a[DATA_W-1],
                      mult_req_i.operand_a};
  assign op_b_ext  = {mult_req_i.signed_mode[0] & mult_req_i.operand_b[DATA_W-1],
                      mult_req_i.operand_b};
  assign prod_full = op_a_ext * op_b_ext;

  // A new MULH only starts from IDLE
  assign mulh_start = mult_en_i && (mult_req_i.op == MULH) && (state_q == IDLE);

  // Product capture in the first MULH cycle
  always_ff @(posedge clk) begin
    if (mulh_start) begin
      prod_q <= prod_full[2*DATA_W-1:0];
    end
  end

  ////////////////////
  // Control
  ////////////////////

  always_comb begin
    state_d      = state_q;
    ready_o      = 1'b1;
    multicycle_o = 1'b0;
    // MUL by default, MAC adds C
    result_o     = (mult_req_i.op == MAC) ? mac_lo : mul_lo;

    unique case (state_q)
      IDLE: begin
        if (mulh_start) begin
          // Hold the stage while the product is registered
          ready_o = 1'b0;
          state_d = HIGH_DONE;
        end
      end
      HIGH_DONE: begin
        result_o     = prod_q[2*DATA_W-1:DATA_W];
        multicycle_o = 1'b1;
        // Stay here under back-pressure so the result holds
        if (ex_ready_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// ==== src/ex_pkg.sv ====
// Execute stage package: widths, vector types, operator and state enums, request and wb structs

package ex_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // Data path width of the integer core
  localparam int DATA_W     = 32;
  // Register file address, 6 bits covers integer and extended registers
  localparam int REG_ADDR_W = 6;
  // Shift amount taken from the low bits of operand B
  localparam int SHAMT_W    = 5;

  // Operand, result and CSR/LSU data word
  typedef logic [DATA_W-1:0]     word_t;
  // Register file write address
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  ////////////////////
  // Operators
  ////////////////////

  // ALU operators, comparisons at the end of the list
  typedef enum logic [3:0] {
    ADD, SUB, AND, OR, XOR,
    SLL, SRL, SRA,
    SLT, SLTU,
    EQ, NE, LT, GE, LTU, GEU
  } alu_op_e;

  // Multiplier operators
  typedef enum logic [1:0] {
    MUL,
    MAC,
    MULH
  } mult_op_e;

  // High-half multiply sequencing
  typedef enum logic {
    IDLE,
    HIGH_DONE
  } mult_state_e;

  ////////////////////
  // Request structs
  ////////////////////

  // ALU request from ID
  typedef struct packed {
    alu_op_e op;
    word_t   operand_a;
    word_t   operand_b;
  } alu_req_t;

  // Multiplier request from ID
  // signed_mode[1] marks A signed, signed_mode[0] marks B signed (MULH only)
  typedef struct packed {
    mult_op_e   op;
    word_t      operand_a;
    word_t      operand_b;
    word_t      operand_c;
    logic [1:0] signed_mode;
  } mult_req_t;

  // Register file write control
  typedef struct packed {
    logic      we;
    reg_addr_t waddr;
  } wb_ctrl_t;

endpackage

// ==== src/ex_stage.sv ====
// Execute stage top: ALU, multiplier, forwarding/stall logic and EX/WB register

`timescale 1ns/1ps

module ex_stage import ex_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,

  // ALU request
  input  logic      alu_en_i,
  input  alu_req_t  alu_req_i,
  input  word_t     operand_c_i,

  // Multiplier request
  input  logic      mult_en_i,
  input  mult_req_t mult_req_i,

  // CSR read data
  input  logic      csr_access_i,
  input  word_t     csr_rdata_i,

  // Write controls for the two RF ports
  input  wb_ctrl_t  alu_wb_i,
  input  wb_ctrl_t  lsu_wb_i,

  // LSU
  input  logic      lsu_en_i,
  input  logic      lsu_ready_ex_i,
  input  logic      lsu_err_i,
  input  word_t     lsu_rdata_i,

  input  logic      branch_in_ex_i,
  input  logic      wb_ready_i,

  // Forwarding port, RF and ID
  output wb_ctrl_t  fwd_o,
  output word_t     fwd_wdata_o,

  // Write-back port, LSU results
  output wb_ctrl_t  wb_o,
  output word_t     wb_wdata_o,

  // To IF
  output word_t     jump_target_o,
  output logic      branch_decision_o,

  output logic      mult_multicycle_o,
  output logic      ex_ready_o,
  output logic      ex_valid_o
);

  word_t alu_result;
  logic  alu_cmp;
  word_t mult_result;
  logic  mult_ready;

  ////////////////////
  // Branch
  ////////////////////

  // Target computed in ID, decision from the ALU compare
  assign jump_target_o     = operand_c_i;
  assign branch_decision_o = alu_cmp;

  ex_alu i_alu (
    .alu_req_i    (alu_req_i),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp)
  );

  // ex_ready closes the loop so MULH knows its result was taken
  ex_mult i_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .mult_en_i    (mult_en_i),
    .mult_req_i   (mult_req_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .ready_o      (mult_ready),
    .multicycle_o (mult_multicycle_o)
  );

  ex_fwd_stall i_fwd_stall (
    .alu_en_i       (alu_en_i),
    .mult_en_i      (mult_en_i),
    .csr_access_i   (csr_access_i),
    .lsu_en_i       (lsu_en_i),
    .alu_result_i   (alu_result),
    .mult_result_i  (mult_result),
    .csr_rdata_i    (csr_rdata_i),
    .alu_wb_i       (alu_wb_i),
    .mult_ready_i   (mult_ready),
    .lsu_ready_ex_i (lsu_ready_ex_i),
    .wb_ready_i     (wb_ready_i),
    .branch_in_ex_i (branch_in_ex_i),
    .fwd_o          (fwd_o),
    .fwd_wdata_o    (fwd_wdata_o),
    .ex_ready_o     (ex_ready_o),
    .ex_valid_o     (ex_valid_o)
  );

  ex_wb_reg i_wb_reg (
    .clk         (clk),
    .rst_n       (rst_n),
    .ex_valid_i  (ex_valid_o),
    .wb_ready_i  (wb_ready_i),
    .lsu_err_i   (lsu_err_i),
    .lsu_wb_i    (lsu_wb_i),
    .lsu_rdata_i (lsu_rdata_i),
    .wb_o        (wb_o),
    .wb_wdata_o  (wb_wdata_o)
  );

endmodule

// ==== src/ex_wb_reg.sv ====
// EX/WB pipeline register for the LSU write-back port

`timescale 1ns/1ps

module ex_wb_reg import ex_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,

  input  logic     ex_valid_i,
  input  logic     wb_ready_i,
  // Faulting load must not write the RF
  input  logic     lsu_err_i,

  // LSU port write control from ID
  input  wb_ctrl_t lsu_wb_i,
  input  word_t    lsu_rdata_i,

  // Write-back port
  output wb_ctrl_t wb_o,
  output word_t    wb_wdata_o
);

  // Registered write control
  wb_ctrl_t wb_q;
  // Enable after error suppression
  logic     we_next;

  assign we_next = lsu_wb_i.we & ~lsu_err_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_q <= '0;
    end else if (ex_valid_i) begin
      // wb_ready is implied by ex_valid
      wb_q.we <= we_next;
      // Address only moves with a real write
      if (we_next) begin
        wb_q.waddr <= lsu_wb_i.waddr;
      end
    end else if (wb_ready_i) begin
      // WB drained and nothing new, flush the slot
      wb_q.we <= 1'b0;
    end
  end

  assign wb_o = wb_q;
  // Load data arrives in WB, no register on it here
  assign wb_wdata_o = lsu_rdata_i;

endmodule

// ==== tb/ex_stage_properties.sv ====
// Concurrent checks on ex_valid levels, MULH result handover and WB state after reset

`timescale 1ns/1ps

module ex_stage_properties import ex_pkg::*; (
  input logic     clk,
  input logic     rst_n,
  input logic     ex_valid_i,
  input logic     ex_ready_i,
  input logic     wb_ready_i,
  input logic     lsu_ready_ex_i,
  input logic     multicycle_i,
  input wb_ctrl_t wb_i
);

  // Count of failed properties
  int fail_cnt = 0;

  // Valid only leaves EX when LSU and WB can take it
  valid_needs_ready: assert property (
    @(posedge clk) disable iff (!rst_n)
    ex_valid_i |-> (wb_ready_i && lsu_ready_ex_i)
  ) else begin
    $error("ex_valid_o high while LSU or WB is not ready");
    fail_cnt++;
  end

  // A consumed high half is gone in the next cycle
  mulh_handover: assert property (
    @(posedge clk) disable iff (!rst_n)
    (multicycle_i && ex_ready_i) |=> !multicycle_i
  ) else begin
    $error("mult_multicycle_o still high after the MULH result was taken");
    fail_cnt++;
  end

  // WB port starts empty
  wb_empty_after_reset: assert property (
    @(posedge clk) $rose(rst_n) |-> !wb_i.we
  ) else begin
    $error("write-back enable high in the first cycle after reset");
    fail_cnt++;
  end

endmodule

bind ex_stage ex_stage_properties props0 (
  .clk            (clk),
  .rst_n          (rst_n),
  .ex_valid_i     (ex_valid_o),
  .ex_ready_i     (ex_ready_o),
  .wb_ready_i     (wb_ready_i),
  .lsu_ready_ex_i (lsu_ready_ex_i),
  .multicycle_i   (mult_multicycle_o),
  .wb_i           (wb_o)
);

// ==== tb/ex_stage_tb.sv ====
// Execute stage testbench with stimulus table, reference model, check loop, watchdog and report

`timescale 1ns/1ps

module ex_stage_tb import ex_pkg::*; ();

  // Outputs sampled a quarter period after the falling edge
  localparam int SETTLE_NS = 25;

  typedef enum {K_ALU, K_MUL, K_MULH, K_PRIO, K_WB, K_STALL} kind_e;

  // Table row whose ctrl bits depend on the kind
  typedef struct {
    kind_e      kind;
    logic [3:0] op;
    logic [2:0] ctrl;
    word_t      a;
    word_t      b;
    word_t      c;
    bit         rnd;
  } vec_t;

  logic        clk;
  logic        rst_n;
  logic        alu_en;
  alu_req_t    alu_req;
  word_t       operand_c;
  logic        mult_en;
  mult_req_t   mult_req;
  logic        csr_access;
  word_t       csr_rdata;
  wb_ctrl_t    alu_wb;
  wb_ctrl_t    lsu_wb;
  logic        lsu_en;
  logic        lsu_ready_ex;
  logic        lsu_err;
  word_t       lsu_rdata;
  logic        branch_in_ex;
  logic        wb_ready;
  wb_ctrl_t    fwd;
  word_t       fwd_wdata;
  wb_ctrl_t    wb;
  word_t       wb_wdata;
  word_t       jump_target;
  logic        branch_decision;
  logic        mult_multicycle;
  logic        ex_ready;
  logic        ex_valid;

  vec_t        tbl[$];
  logic [31:0] rng_state = 32'd71;
  int          err_cnt;
  int          pass_cnt;
  int          fail_cnt;

  tb_clkgen clkgen0 (.clk_o(clk));

  ex_stage dut0 (
    .clk (clk), .rst_n (rst_n),
    .alu_en_i (alu_en), .alu_req_i (alu_req), .operand_c_i (operand_c),
    .mult_en_i (mult_en), .mult_req_i (mult_req),
    .csr_access_i (csr_access), .csr_rdata_i (csr_rdata),
    .alu_wb_i (alu_wb), .lsu_wb_i (lsu_wb),
    .lsu_en_i (lsu_en), .lsu_ready_ex_i (lsu_ready_ex), .lsu_err_i (lsu_err),
    .lsu_rdata_i (lsu_rdata), .branch_in_ex_i (branch_in_ex), .wb_ready_i (wb_ready),
    .fwd_o (fwd), .fwd_wdata_o (fwd_wdata), .wb_o (wb), .wb_wdata_o (wb_wdata),
    .jump_target_o (jump_target), .branch_decision_o (branch_decision),
    .mult_multicycle_o (mult_multicycle), .ex_ready_o (ex_ready), .ex_valid_o (ex_valid)
  );

  ////////////////////
  // Reference model
  ////////////////////

  function automatic word_t xorshift();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  // Returns {cmp, result}
  function automatic logic [32:0] alu_model(input alu_op_e op, input word_t a, input word_t b);
    logic  lt_s;
    logic  lt_u;
    logic  c;
    word_t r;
    int    sh;
    sh   = b[4:0];
    lt_u = a < b;
    // Signed order by flipping the sign bits
    lt_s = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
    c    = 1'b0;
    r    = '0;
    case (op)
      ADD:  r = a + b;
      SUB:  r = a - b;
      AND:  r = a & b;
      OR:   r = a | b;
      XOR:  r = a ^ b;
      SLL:  r = a << sh;
      SRL:  r = a >> sh;
      SRA:  r = (a >> sh) | ({32{a[31]}} & ~(32'hFFFF_FFFF >> sh));
      SLT, LT:   c = lt_s;
      SLTU, LTU: c = lt_u;
      EQ:   c = (a == b);
      NE:   c = (a != b);
      GE:   c = !lt_s;
      GEU:  c = !lt_u;
    endcase
    if (op >= SLT) begin
      r = {31'b0, c};
    end
    return {c, r};
  endfunction

  // High half of a 64-bit product with sign extension per mode bit
  function automatic word_t mulh_model(input word_t a, input word_t b, input logic [1:0] sm);
    logic [63:0] ax;
    logic [63:0] bx;
    logic [63:0] p;
    ax = {(sm[1] ? {32{a[31]}} : 32'h0), a};
    bx = {(sm[0] ? {32{b[31]}} : 32'h0), b};
    p  = ax * bx;
    return p[63:32];
  endfunction

  ////////////////////
  // Helpers
  ////////////////////

  task automatic check_eq(input word_t got, input word_t exp, input string what);
    assert (got === exp) else begin
      $display("ERROR @%0t ns: %s got %h expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic close_test(input int idx, input string name, input int errs_before);
    if (err_cnt == errs_before) begin
      pass_cnt++;
      $display("test %0d %s: ok", idx, name);
    end else begin
      fail_cnt++;
      $display("test %0d %s: mismatch", idx, name);
    end
  endtask

  function automatic void add_vec(input kind_e k, input logic [3:0] op, input logic [2:0] ctrl,
                                  input word_t a, input word_t b, input word_t c, input bit rnd);
    vec_t v;
    v = '{k, op, ctrl, a, b, c, rnd};
    tbl.push_back(v);
  endfunction

  // Nothing enabled with LSU and WB ready
  task automatic drive_idle();
    alu_en       = 1'b0;
    alu_req      = '0;
    operand_c    = '0;
    mult_en      = 1'b0;
    mult_req     = '0;
    csr_access   = 1'b0;
    csr_rdata    = '0;
    alu_wb       = '0;
    lsu_wb       = '0;
    lsu_en       = 1'b0;
    lsu_ready_ex = 1'b1;
    lsu_err      = 1'b0;
    branch_in_ex = 1'b0;
    wb_ready     = 1'b1;
  endtask

  task automatic build_table();
    for (int op = 0; op < 16; op++) begin
      add_vec(K_ALU, op[3:0], 3'b000, 32'hF000_0005, 32'h0000_0023, 32'h0000_1040, 1'b0);
      add_vec(K_ALU, op[3:0], 3'b000, '0, '0, '0, 1'b1);
    end
    add_vec(K_ALU, EQ, 3'b000, 32'h1234_5678, 32'h1234_5678, 32'h0000_2000, 1'b0);
    // MUL then MAC
    for (int op = 0; op < 2; op++) begin
      add_vec(K_MUL, op[3:0], 3'b000, 32'hFFFF_FFFD, 32'h0001_0007, 32'h0000_0100, 1'b0);
      add_vec(K_MUL, op[3:0], 3'b000, '0, '0, '0, 1'b1);
    end
    // ctrl[1:0] is the signed mode and ctrl[2] holds wb_ready low
    for (int m = 0; m < 4; m++) begin
      add_vec(K_MULH, MULH, {1'b0, m[1:0]}, 32'hFFFF_FFFE, 32'h8000_0003, '0, 1'b0);
      add_vec(K_MULH, MULH, {1'b0, m[1:0]}, '0, '0, '0, 1'b1);
    end
    add_vec(K_MULH, MULH, 3'b111, 32'h8000_0000, 32'h7FFF_FFFF, '0, 1'b0);
    // ctrl[0] adds a CSR access
    add_vec(K_PRIO, ADD, 3'b001, 32'h0000_0011, 32'h0000_0013, 32'hC5C5_0001, 1'b0);
    add_vec(K_PRIO, ADD, 3'b000, 32'h0000_0011, 32'h0000_0013, 32'hC5C5_0001, 1'b0);
    // ctrl[0] sets an LSU error and ctrl[1] adds one cycle of WB back-pressure
    add_vec(K_WB, ADD, 3'b000, 32'h0000_002A, 32'hDEAD_BEEF, '0, 1'b0);
    add_vec(K_WB, ADD, 3'b001, 32'h0000_0015, 32'h0BAD_F00D, '0, 1'b0);
    add_vec(K_WB, ADD, 3'b010, 32'h0000_0033, 32'h1357_9BDF, '0, 1'b0);
    // ctrl bits drive lsu_ready_ex, wb_ready and branch_in_ex from bit 0 up
    add_vec(K_STALL, ADD, 3'b010, 32'h1, 32'h2, '0, 1'b0);
    add_vec(K_STALL, ADD, 3'b001, 32'h1, 32'h2, '0, 1'b0);
    add_vec(K_STALL, ADD, 3'b100, 32'h1, 32'h2, '0, 1'b0);
    add_vec(K_STALL, ADD, 3'b101, 32'h1, 32'h2, '0, 1'b0);
    add_vec(K_STALL, ADD, 3'b111, 32'h1, 32'h2, '0, 1'b0);
  endtask

  ////////////////////
  // Apply one row
  ////////////////////

  task automatic run_vec(input vec_t v);
    logic [32:0] am;
    word_t       exp;
    word_t       a;
    word_t       b;
    word_t       c;
    a = v.a;
    b = v.b;
    c = v.c;
    if (v.rnd) begin
      a = xorshift();
      b = xorshift();
      c = xorshift();
    end
    @(negedge clk);
    drive_idle();
    case (v.kind)
      K_ALU: begin
        am        = alu_model(alu_op_e'(v.op), a, b);
        alu_en    = 1'b1;
        alu_req   = '{alu_op_e'(v.op), a, b};
        operand_c = c;
        alu_wb    = '{1'b1, c[5:0]};
        #SETTLE_NS;
        check_eq(fwd_wdata, am[31:0], "alu result");
        check_eq(word_t'(fwd), word_t'(alu_wb), "forward control");
        check_eq(branch_decision, am[32], "branch decision");
        check_eq(jump_target, c, "jump target");
      end
      K_MUL: begin
        exp = a * b;
        if (v.op[1:0] == MAC) begin
          exp = exp + c;
        end
        mult_en  = 1'b1;
        mult_req = '{mult_op_e'(v.op[1:0]), a, b, c, 2'b00};
        #SETTLE_NS;
        check_eq(fwd_wdata, exp, "mul/mac result");
        check_eq(ex_ready, 1'b1, "ex_ready with single-cycle multiply");
      end
      K_MULH: begin
        exp      = mulh_model(a, b, v.ctrl[1:0]);
        mult_en  = 1'b1;
        mult_req = '{MULH, a, b, c, v.ctrl[1:0]};
        #SETTLE_NS;
        check_eq(ex_ready, 1'b0, "ex_ready in first MULH cycle");
        check_eq(mult_multicycle, 1'b0, "multicycle in first MULH cycle");
        @(negedge clk);
        wb_ready = !v.ctrl[2];
        #SETTLE_NS;
        check_eq(mult_multicycle, 1'b1, "multicycle in second MULH cycle");
        check_eq(ex_ready, !v.ctrl[2], "ex_ready in second MULH cycle");
        check_eq(fwd_wdata, exp, "MULH high half");
        if (v.ctrl[2]) begin
          // Result must not have moved once the back-pressure is released
          @(negedge clk);
          wb_ready = 1'b1;
          #SETTLE_NS;
          check_eq(mult_multicycle, 1'b1, "multicycle after back-pressure");
          check_eq(ex_ready, 1'b1, "ex_ready after back-pressure");
          check_eq(fwd_wdata, exp, "MULH result held");
        end
      end
      K_PRIO: begin
        alu_en     = 1'b1;
        alu_req    = '{ADD, a, b};
        mult_en    = 1'b1;
        mult_req   = '{MUL, a, b, c, 2'b00};
        csr_access = v.ctrl[0];
        csr_rdata  = c;
        exp        = v.ctrl[0] ? c : a * b;
        #SETTLE_NS;
        check_eq(fwd_wdata, exp, "forwarding priority");
      end
      K_WB: begin
        lsu_en    = 1'b1;
        lsu_wb    = '{1'b1, a[5:0]};
        lsu_err   = v.ctrl[0];
        lsu_rdata = b;
        #SETTLE_NS;
        check_eq(ex_valid, 1'b1, "ex_valid with lsu_en");
        @(negedge clk);
        drive_idle();
        wb_ready = !v.ctrl[1];
        #SETTLE_NS;
        check_eq(wb.we, !v.ctrl[0], "wb we after capture");
        if (!v.ctrl[0]) begin
          check_eq(wb.waddr, a[5:0], "wb waddr");
          check_eq(wb_wdata, b, "wb data");
        end
        @(negedge clk);
        wb_ready = 1'b1;
        #SETTLE_NS;
        // Held under back-pressure and cleared otherwise
        check_eq(wb.we, v.ctrl[1] ? !v.ctrl[0] : 1'b0, "wb we after idle cycle");
        if (v.ctrl[1]) begin
          @(negedge clk);
          #SETTLE_NS;
          check_eq(wb.we, 1'b0, "wb we after flush");
        end
      end
      K_STALL: begin
        alu_en       = 1'b1;
        alu_req      = '{ADD, a, b};
        lsu_ready_ex = v.ctrl[0];
        wb_ready     = v.ctrl[1];
        branch_in_ex = v.ctrl[2];
        #SETTLE_NS;
        check_eq(ex_ready, (v.ctrl[0] & v.ctrl[1]) | v.ctrl[2], "ex_ready stall rule");
        check_eq(ex_valid, v.ctrl[0] & v.ctrl[1], "ex_valid stall rule");
      end
    endcase
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    int errs_before;
    drive_idle();
    rst_n     = 1'b0;
    lsu_rdata = '0;
    err_cnt   = 0;
    pass_cnt  = 0;
    fail_cnt  = 0;
    build_table();
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    // Test 0 is the reset state of the WB port
    errs_before = err_cnt;
    #SETTLE_NS;
    check_eq(wb.we, 1'b0, "wb we after reset");
    check_eq(mult_multicycle, 1'b0, "multicycle after reset");
    close_test(0, "RESET", errs_before);
    foreach (tbl[i]) begin
      errs_before = err_cnt;
      run_vec(tbl[i]);
      close_test(i + 1, tbl[i].kind.name(), errs_before);
    end
    $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors, %0d property errors",
             pass_cnt + fail_cnt, pass_cnt, fail_cnt, err_cnt, dut0.props0.fail_cnt);
    if (fail_cnt == 0 && dut0.props0.fail_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // Watchdog sized from the table once it is built
  initial begin
    int limit;
    #1;
    limit = tbl.size() * 4 + 20;
    repeat (limit) @(posedge clk);
    $display("Timeout: the tests did not finish within %0d cycles", limit);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

// ==== tb/tb_clkgen.sv ====
// Free-running testbench clock generator, 100 ns period

`timescale 1ns/1ps

module tb_clkgen (
  output logic clk_o
);

  // Half of the 100 ns period
  localparam int HALF_PERIOD_NS = 50;

  // Starts low, first rising edge at 50 ns
  initial begin
    clk_o = 1'b0;
    forever begin
      #HALF_PERIOD_NS;
      clk_o = ~clk_o;
    end
  end

endmodule
